//--- rtl/cache_pkg.sv
`default_nettype none

package cache_pkg;

   // ------------------------------------------------------------------------
   // Words and cache storage
   // ------------------------------------------------------------------------

   typedef logic [31:0] word_t;

   // Tag field sized for the smallest index width.
   // Modules compare and store only the low bits they need.
   localparam int MIN_IDX_W = 1;
   localparam int TAG_W     = 32 - MIN_IDX_W - 3;

   typedef struct packed {
      logic [TAG_W-1:0] tag;
      word_t            dat0;
      word_t            dat1;
      logic             dirty;
      logic             valid;
   } frame_t;

   typedef struct packed {
      frame_t left;
      frame_t right;
   } set_t;

   // ------------------------------------------------------------------------
   // Datapath side
   // ------------------------------------------------------------------------

   typedef struct packed {
      logic  ren;
      logic  wen;
      logic  halt;
      word_t addr;
      word_t store;
   } dp_req_t;

   typedef struct packed {
      logic  hit;
      word_t load;
      logic  flushed;
   } dp_rsp_t;

   // ------------------------------------------------------------------------
   // Memory bus side
   // ------------------------------------------------------------------------

   typedef struct packed {
      logic  ren;
      logic  wen;
      word_t addr;
      word_t store;
   } mem_req_t;

   typedef struct packed {
      logic  dwait;
      word_t load;
   } mem_rsp_t;

endpackage

`default_nettype wire

//--- rtl/dcache_store.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_store
   import cache_pkg::*;
#(
   parameter int NSETS = 8,
   localparam int IW = $clog2(NSETS)
)
(
   input  logic          CLK,
   input  logic          nRST,
   input  logic [IW-1:0] rd_index,
   input  logic [IW-1:0] fl_index,
   input  logic          wr_en,
   input  logic [IW-1:0] wr_index,
   input  set_t          wr_set,
   input  logic          lru_en,
   input  logic          lru_val,
   output set_t          rd_set,
   output set_t          fl_set,
   output logic          rd_lru
);

   // Tag and data storage.
   set_t sets [NSETS];

   // Per-set flags in order left dirty, left valid, right dirty, right valid.
   logic [3:0]       flags [NSETS];
   // LRU bit names the way to evict next.
   logic [NSETS-1:0] lru;

   // Replace the stored flag fields with the live flag bits.
   function automatic set_t with_flags(input set_t s, input logic [3:0] f);
      set_t r;
      r = s;
      r.left.dirty  = f[3];
      r.left.valid  = f[2];
      r.right.dirty = f[1];
      r.right.valid = f[0];
      return r;
   endfunction

   always_ff @(posedge CLK)
   begin
      if (wr_en)
      begin
         sets[wr_index] <= wr_set;
      end
   end

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         for (int i = 0; i < NSETS; i++)
         begin
            flags[i] <= '0;
         end
         lru <= '0;
      end
      else
      begin
         if (wr_en)
         begin
            flags[wr_index] <= {wr_set.left.dirty, wr_set.left.valid,
                                wr_set.right.dirty, wr_set.right.valid};
         end
         if (lru_en)
         begin
            lru[wr_index] <= lru_val;
         end
      end
   end

   // Both read ports are combinational.
   always_comb
   begin
      rd_set = with_flags(sets[rd_index], flags[rd_index]);
      fl_set = with_flags(sets[fl_index], flags[fl_index]);
   end

   assign rd_lru = lru[rd_index];

endmodule

`default_nettype wire

//--- rtl/dcache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl
   import cache_pkg::*;
#(
   parameter int    NSETS      = 8,
   parameter word_t COUNT_ADDR = 32'h3100,
   localparam int   IW         = $clog2(NSETS)
)
(
   input  logic          CLK,
   input  logic          nRST,
   input  dp_req_t       dp_req,
   output dp_rsp_t       dp_rsp,
   output mem_req_t      mem_req,
   input  mem_rsp_t      mem_rsp,
   output logic [IW-1:0] rd_index,
   output logic [IW-1:0] fl_index,
   output logic          wr_en,
   output logic [IW-1:0] wr_index,
   output set_t          wr_set,
   output logic          lru_en,
   output logic          lru_val,
   input  set_t          rd_set,
   input  set_t          fl_set,
   input  logic          rd_lru
);

   localparam int TW = 32 - IW - 3;

   typedef enum logic [3:0] {
      IDLE, WB0, WB1, RD0, RD1, FL_SCAN, FL_WB0, FL_WB1, COUNT, DONE
   } state_t;

   state_t           state, next_state;
   logic [TAG_W-1:0] addr_tag;
   logic [IW-1:0]    addr_idx;
   logic             word_sel;
   logic             req, hit_l, hit_r, hit, miss, xfer;
   frame_t           hit_frame, victim, fl_frame, merged, new_frame;
   logic [IW:0]      fl_cnt;
   logic             fl_last, fl_dirty;
   word_t            hit_count;
   word_t            refill_w0;

   function automatic word_t blk_addr(input logic [TAG_W-1:0] tag,
                                      input logic [IW-1:0] idx,
                                      input logic sel);
      return {tag[TW-1:0], idx, sel, 2'b00};
   endfunction

   // ------------------------------------------------------------------------
   // Lookup
   // ------------------------------------------------------------------------

   assign addr_tag = TAG_W'(dp_req.addr[31:IW+3]);
   assign addr_idx = dp_req.addr[IW+2:3];
   assign word_sel = dp_req.addr[2];
   assign rd_index = addr_idx;

   assign req   = (dp_req.ren | dp_req.wen) & ~dp_req.halt;
   assign hit_l = rd_set.left.valid && (rd_set.left.tag == addr_tag);
   assign hit_r = rd_set.right.valid && (rd_set.right.tag == addr_tag);
   assign hit   = (state == IDLE) && req && (hit_l || hit_r);
   assign miss  = (state == IDLE) && req && !(hit_l || hit_r);
   assign xfer  = !mem_rsp.dwait;

   assign hit_frame = hit_l ? rd_set.left : rd_set.right;
   assign victim    = rd_lru ? rd_set.right : rd_set.left;

   // Flush walk covers all left ways, then all right ways.
   assign fl_index = fl_cnt[IW-1:0];
   assign fl_frame = fl_cnt[IW] ? fl_set.right : fl_set.left;
   assign fl_dirty = fl_frame.valid && fl_frame.dirty;
   assign fl_last  = &fl_cnt;

   always_comb
   begin
      dp_rsp.hit     = hit;
      dp_rsp.load    = word_sel ? hit_frame.dat1 : hit_frame.dat0;
      dp_rsp.flushed = (state == COUNT) || (state == DONE);
   end

   // ------------------------------------------------------------------------
   // Store updates
   // ------------------------------------------------------------------------

   always_comb
   begin
      merged = hit_frame;
      merged.dirty = 1'b1;
      if (word_sel)
      begin
         merged.dat1 = dp_req.store;
      end
      else
      begin
         merged.dat0 = dp_req.store;
      end

      new_frame = '{tag: addr_tag, dat0: refill_w0, dat1: mem_rsp.load,
                    dirty: 1'b0, valid: 1'b1};

      wr_en    = 1'b0;
      wr_index = addr_idx;
      wr_set   = rd_set;
      lru_en   = 1'b0;
      lru_val  = 1'b0;

      if (hit)
      begin
         // Point LRU at the way not used.
         lru_en  = 1'b1;
         lru_val = hit_l;
         if (dp_req.wen)
         begin
            wr_en = 1'b1;
            if (hit_l)
            begin
               wr_set.left = merged;
            end
            else
            begin
               wr_set.right = merged;
            end
         end
      end
      else if (state == RD1 && xfer)
      begin
         wr_en   = 1'b1;
         lru_en  = 1'b1;
         lru_val = ~rd_lru;
         if (rd_lru)
         begin
            wr_set.right = new_frame;
         end
         else
         begin
            wr_set.left = new_frame;
         end
      end
   end

   // ------------------------------------------------------------------------
   // Memory bus
   // ------------------------------------------------------------------------

   always_comb
   begin
      mem_req = '0;
      case (state)
         WB0, WB1:
         begin
            mem_req.wen   = 1'b1;
            mem_req.addr  = blk_addr(victim.tag, addr_idx, state == WB1);
            mem_req.store = (state == WB1) ? victim.dat1 : victim.dat0;
         end
         RD0, RD1:
         begin
            mem_req.ren  = 1'b1;
            mem_req.addr = blk_addr(addr_tag, addr_idx, state == RD1);
         end
         FL_WB0, FL_WB1:
         begin
            mem_req.wen   = 1'b1;
            mem_req.addr  = blk_addr(fl_frame.tag, fl_index, state == FL_WB1);
            mem_req.store = (state == FL_WB1) ? fl_frame.dat1 : fl_frame.dat0;
         end
         COUNT:
         begin
            mem_req.wen   = 1'b1;
            mem_req.addr  = COUNT_ADDR;
            mem_req.store = hit_count;
         end
         default:
         begin
            mem_req = '0;
         end
      endcase
   end

   // ------------------------------------------------------------------------
   // FSM
   // ------------------------------------------------------------------------

   always_comb
   begin
      next_state = state;
      case (state)
         IDLE:
         begin
            if (dp_req.halt)
            begin
               next_state = FL_SCAN;
            end
            else if (miss)
            begin
               next_state = (victim.valid && victim.dirty) ? WB0 : RD0;
            end
         end
         WB0:     next_state = xfer ? WB1 : WB0;
         WB1:     next_state = xfer ? RD0 : WB1;
         RD0:     next_state = xfer ? RD1 : RD0;
         RD1:     next_state = xfer ? IDLE : RD1;
         FL_SCAN:
         begin
            if (fl_dirty)
            begin
               next_state = FL_WB0;
            end
            else if (fl_last)
            begin
               next_state = COUNT;
            end
         end
         FL_WB0:  next_state = xfer ? FL_WB1 : FL_WB0;
         FL_WB1:
         begin
            if (xfer)
            begin
               next_state = fl_last ? COUNT : FL_SCAN;
            end
         end
         COUNT:   next_state = xfer ? DONE : COUNT;
         default: next_state = DONE;
      endcase
   end

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         state     <= IDLE;
         fl_cnt    <= '0;
         hit_count <= '0;
      end
      else
      begin
         state <= next_state;
         if (hit)
         begin
            hit_count <= hit_count + 32'd1;
         end
         else if (miss)
         begin
            hit_count <= hit_count - 32'd1;
         end
         if (state == IDLE)
         begin
            fl_cnt <= '0;
         end
         else if (((state == FL_SCAN) && !fl_dirty && !fl_last) ||
                  ((state == FL_WB1) && xfer && !fl_last))
         begin
            fl_cnt <= fl_cnt + 1'b1;
         end
      end
   end

   // First refill word waits here until the second arrives.
   always_ff @(posedge CLK)
   begin
      if (state == RD0 && xfer)
      begin
         refill_w0 <= mem_rsp.load;
      end
   end

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_top
   import cache_pkg::*;
#(
   parameter int    NSETS      = 8,
   parameter word_t COUNT_ADDR = 32'h3100
)
(
   input  logic     CLK,
   input  logic     nRST,
   input  dp_req_t  dp_req,
   output dp_rsp_t  dp_rsp,
   output mem_req_t mem_req,
   input  mem_rsp_t mem_rsp
);

   localparam int IW = $clog2(NSETS);

   logic [IW-1:0] rd_index, fl_index, wr_index;
   logic          wr_en, lru_en, lru_val, rd_lru;
   set_t          wr_set, rd_set, fl_set;

   dcache_ctrl #(
      .NSETS      (NSETS),
      .COUNT_ADDR (COUNT_ADDR)
   ) ctrl_i (
      .CLK      (CLK),
      .nRST     (nRST),
      .dp_req   (dp_req),
      .dp_rsp   (dp_rsp),
      .mem_req  (mem_req),
      .mem_rsp  (mem_rsp),
      .rd_index (rd_index),
      .fl_index (fl_index),
      .wr_en    (wr_en),
      .wr_index (wr_index),
      .wr_set   (wr_set),
      .lru_en   (lru_en),
      .lru_val  (lru_val),
      .rd_set   (rd_set),
      .fl_set   (fl_set),
      .rd_lru   (rd_lru)
   );

   dcache_store #(
      .NSETS (NSETS)
   ) store_i (
      .CLK      (CLK),
      .nRST     (nRST),
      .rd_index (rd_index),
      .fl_index (fl_index),
      .wr_en    (wr_en),
      .wr_index (wr_index),
      .wr_set   (wr_set),
      .lru_en   (lru_en),
      .lru_val  (lru_val),
      .rd_set   (rd_set),
      .fl_set   (fl_set),
      .rd_lru   (rd_lru)
   );

endmodule

`default_nettype wire

//--- tb/tb_clkgen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
   parameter int PERIOD     = 100,
   parameter int RST_CYCLES = 4
)
(
   output logic CLK,
   output logic nRST
);

   initial
   begin
      CLK = 1'b0;
      forever #(PERIOD / 2) CLK = ~CLK;
   end

   // Reset released a little after an edge.
   initial
   begin
      nRST = 1'b0;
      repeat (RST_CYCLES) @(posedge CLK);
      #10 nRST = 1'b1;
   end

endmodule

`default_nettype wire

//--- tb/dcache_assert.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_assert
   import cache_pkg::*;
(
   input logic     CLK,
   input logic     nRST,
   input mem_req_t mem_req,
   input mem_rsp_t mem_rsp,
   input dp_rsp_t  dp_rsp
);

   // Bus never reads and writes at once.
   a_rw_excl: assert property (@(posedge CLK) disable iff (!nRST)
      !(mem_req.ren && mem_req.wen))
      else $error("memory read and write enable high together");

   // Stalled transfer holds its request.
   a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
      ((mem_req.ren || mem_req.wen) && mem_rsp.dwait) |=> $stable(mem_req))
      else $error("memory request changed while wait was high");

   a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
      dp_rsp.flushed |=> dp_rsp.flushed)
      else $error("flushed fell after rising");

endmodule

bind dcache_ctrl dcache_assert assert_i (
   .CLK     (CLK),
   .nRST    (nRST),
   .mem_req (mem_req),
   .mem_rsp (mem_rsp),
   .dp_rsp  (dp_rsp)
);

`default_nettype wire

//--- tb/tb_dcache.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dcache
   import cache_pkg::*;
();

   localparam word_t COUNT_ADDR = 32'h3100;
   localparam word_t MEM_XOR    = 32'h5A5A0000;
   localparam int    MEM_WORDS  = 4096;
   localparam int    PAT_WORDS  = 128;
   localparam int    MAX_WAIT   = 200;

   logic     CLK, nRST;
   dp_req_t  dp_req;
   dp_rsp_t  dp_rsp;
   mem_req_t mem_req;
   mem_rsp_t mem_rsp;

   word_t    mem [MEM_WORDS];
   word_t    pat [PAT_WORDS];
   int       wait_cnt;
   int       wr_count;
   integer   seed;
   int       mismatches;
   int       failures;

   tb_clkgen clkgen_i (
      .CLK  (CLK),
      .nRST (nRST)
   );

   dcache_top #(
      .NSETS      (8),
      .COUNT_ADDR (COUNT_ADDR)
   ) dut_i (
      .CLK     (CLK),
      .nRST    (nRST),
      .dp_req  (dp_req),
      .dp_rsp  (dp_rsp),
      .mem_req (mem_req),
      .mem_rsp (mem_rsp)
   );

   // ------------------------------------------------------------------------
   // Memory model
   // ------------------------------------------------------------------------

   always_comb
   begin
      mem_rsp.dwait = (wait_cnt != 0);
      mem_rsp.load  = mem[mem_req.addr[13:2]];
   end

   // Wait count changes shortly after the edge like the other inputs.
   always @(posedge CLK)
   begin
      int next_cnt;
      if (nRST && (mem_req.ren || mem_req.wen))
      begin
         if (wait_cnt == 0)
         begin
            if (mem_req.wen)
            begin
               mem[mem_req.addr[13:2]] <= mem_req.store;
               wr_count <= wr_count + 1;
            end
            next_cnt = $random(seed) & 3;
         end
         else
         begin
            next_cnt = wait_cnt - 1;
         end
         #10 wait_cnt = next_cnt;
      end
   end

   // ------------------------------------------------------------------------
   // Compare tasks
   // ------------------------------------------------------------------------

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (exp !== act)
      begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         mismatches++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act)
      begin
         $display("MISMATCH %s expected %b actual %b", name, exp, act);
         mismatches++;
      end
   endtask

   // ------------------------------------------------------------------------
   // Operations
   // ------------------------------------------------------------------------

   task automatic do_access(input int line, input logic wr, input logic exp_hit,
                            input word_t addr, input word_t data, input word_t exp);
      int    cycles;
      int    wr_before;
      logic  got;
      word_t load;
      string name;
      name = $sformatf("line %0d %s %h", line, wr ? "store" : "load", addr);
      wr_before = wr_count;
      @(posedge CLK);
      #10;
      dp_req = '{ren: ~wr, wen: wr, halt: 1'b0, addr: addr, store: data};
      cycles = 0;
      got = 1'b0;
      load = '0;
      while (!got && cycles < MAX_WAIT)
      begin
         @(negedge CLK);
         if (dp_rsp.hit)
         begin
            got = 1'b1;
            load = dp_rsp.load;
         end
         else
         begin
            cycles++;
         end
      end
      if (!got)
      begin
         $display("%s never saw a hit within %0d cycles", name, MAX_WAIT);
         failures++;
      end
      else
      begin
         check_flag({name, " first cycle hit"}, exp_hit, cycles == 0);
         if (!wr)
         begin
            check_word(name, exp, load);
         end
      end
      @(posedge CLK);
      #10 dp_req = '0;
      // A hit completes without any memory write.
      if (got && exp_hit)
      begin
         check_word({name, " bus writes"}, 32'd0, word_t'(wr_count - wr_before));
      end
   endtask

   task automatic do_halt(input int line, input word_t exp_count);
      int cycles;
      @(posedge CLK);
      #10 dp_req = '{ren: 1'b0, wen: 1'b0, halt: 1'b1, addr: '0, store: '0};
      cycles = 0;
      @(negedge CLK);
      while (!dp_rsp.flushed && cycles < 10 * MAX_WAIT)
      begin
         @(negedge CLK);
         cycles++;
      end
      check_flag($sformatf("line %0d flushed", line), 1'b1, dp_rsp.flushed);
      cycles = 0;
      while (mem_req.wen && cycles < MAX_WAIT)
      begin
         @(negedge CLK);
         cycles++;
      end
      if (mem_req.wen)
      begin
         $display("line %0d hit count write never completed", line);
         failures++;
      end
      check_word($sformatf("line %0d hit count", line), exp_count,
                 mem[COUNT_ADDR[13:2]]);
   endtask

   // ------------------------------------------------------------------------
   // Pattern replay
   // ------------------------------------------------------------------------

   initial
   begin
      int    i;
      int    cycles;
      word_t op, addr, data, exp;
      dp_req = '0;
      wait_cnt = 0;
      wr_count = 0;
      seed = 32'h9893;
      mismatches = 0;
      failures = 0;
      for (int a = 0; a < MEM_WORDS; a++)
      begin
         mem[a] = word_t'(a << 2) ^ MEM_XOR;
      end
      $readmemh("tb/dcache_patterns.txt", pat);
      cycles = 0;
      while (!nRST && cycles < 20)
      begin
         @(posedge CLK);
         cycles++;
      end
      if (!nRST)
      begin
         $display("reset was never released");
         failures++;
      end
      i = 0;
      op = pat[0];
      while (op !== 32'hF && i < PAT_WORDS / 4)
      begin
         addr = pat[4 * i + 1];
         data = pat[4 * i + 2];
         exp  = pat[4 * i + 3];
         case (op)
            0: do_access(i, 1'b0, 1'b1, addr, data, exp);
            1: do_access(i, 1'b0, 1'b0, addr, data, exp);
            2: do_access(i, 1'b1, 1'b1, addr, data, exp);
            3: do_access(i, 1'b1, 1'b0, addr, data, exp);
            4: do_halt(i, exp);
            5: check_word($sformatf("line %0d memory %h", i, addr), exp,
                          mem[addr[13:2]]);
            default:
            begin
               $display("line %0d has an unknown operation %h", i, op);
               failures++;
            end
         endcase
         i++;
         op = pat[4 * i];
      end
      $display("errors: mismatches %0d, other failures %0d", mismatches, failures);
      if (mismatches == 0 && failures == 0)
      begin
         $display("test passed");
      end
      else
      begin
         $display("test failed");
      end
      $finish;
   end

   // Whole run limit.
   initial
   begin
      #2000000;
      $display("simulation ran past its time limit");
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb/dcache_patterns.txt
// op addr store expected; op 0 load hit, 1 load miss, 2 store hit, 3 store miss
// op 4 halt with expected hit count, 5 memory check, F end
1 00000100 00000000 5A5A0100
0 00000104 00000000 5A5A0104
0 00000100 00000000 5A5A0100
3 00000108 11112222 00000000
0 00000108 00000000 11112222
5 00000108 00000000 5A5A0108
2 0000010C 33334444 00000000
0 0000010C 00000000 33334444
2 00000100 AAAA0001 00000000
1 00000200 00000000 5A5A0200
1 00000300 00000000 5A5A0300
5 00000100 00000000 AAAA0001
5 00000104 00000000 5A5A0104
1 00000100 00000000 AAAA0001
2 00000304 BEEF0304 00000000
3 00000010 01234567 00000000
2 00000014 89ABCDEF 00000000
4 00000000 00000000 00000008
5 00000100 00000000 AAAA0001
5 00000108 00000000 11112222
5 0000010C 00000000 33334444
5 00000304 00000000 BEEF0304
5 00000300 00000000 5A5A0300
5 00000010 00000000 01234567
5 00000014 00000000 89ABCDEF
5 00003100 00000000 00000008
F 00000000 00000000 00000000

//--- vlog.f
rtl/cache_pkg.sv
rtl/dcache_store.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
tb/tb_clkgen.sv
tb/dcache_assert.sv
tb/tb_dcache.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) \
		-f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^test passed$$" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
